/* Bender.yml */
package:
  name: dcache

sources:
  - rtl/dcache_pkg.sv
  - rtl/dcache_line_ram.sv
  - rtl/dcache_req_stage.sv
  - rtl/dcache_ctrl.sv
  - rtl/dcache_bus_if.sv
  - rtl/dcache_top.sv
  - target: test
    files:
      - dv/dcache_assert.sv
      - dv/dcache_tb.sv

/* dcache.f */
rtl/dcache_pkg.sv
rtl/dcache_line_ram.sv
rtl/dcache_req_stage.sv
rtl/dcache_ctrl.sv
rtl/dcache_bus_if.sv
rtl/dcache_top.sv
dv/dcache_assert.sv
dv/dcache_tb.sv

/* dv/dcache_assert.sv */
// data cache controller checks on stall, go pulses, flush and state encoding
module dcache_assert (
	input logic                    clk,
	input logic                    rst_n,
	input dcache_pkg::miss_state_e state,
	input logic                    stall,
	input logic                    wb_go,
	input logic                    fill_go,
	input logic                    flush_busy,
	input logic                    rsp_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// any state but IDLE holds the core
	busy_stalls: assert property (@(posedge clk) disable iff (!rst_n)
		(state != dcache_pkg::IDLE) |-> stall)
		else begin
			fail_count++;
			$error("stall low while the controller is busy");
		end

	// write-back and fill are strictly sequential
	go_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_go && fill_go))
		else begin
			fail_count++;
			$error("wb_go and fill_go in the same cycle");
		end

	flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		flush_busy |-> !rsp_valid)
		else begin
			fail_count++;
			$error("rsp_valid during flush");
		end

	state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(state) && (state inside {dcache_pkg::IDLE, dcache_pkg::WBACK,
			dcache_pkg::FILL, dcache_pkg::REFILL_WR, dcache_pkg::REREAD,
			dcache_pkg::FLUSH_RD, dcache_pkg::FLUSH_WB}))
		else begin
			fail_count++;
			$error("controller state outside its encoding");
		end

endmodule

bind dcache_ctrl dcache_assert i_assert (
	.clk, .rst_n, .state, .stall, .wb_go, .fill_go, .flush_busy, .rsp_valid
);

/* dv/dcache_tb.sv */
// data cache testbench with random traffic, memory responder and reference model
module dcache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int INDEX_W   = 4;
	localparam int WIN_WORDS = 1024;
	localparam int WIN_LINES = 256;
	localparam int N_REQ     = 600;
	localparam int N_EXTRA   = 48;
	localparam logic [31:0] SEED = 32'h10238293;
	// worst miss is a dirty write-back plus a fill, both at the longest memory delay
	localparam int MISS_CYC    = 32;
	localparam int FLUSH_CYC   = (2 ** INDEX_W) * 16;
	localparam int CYCLE_LIMIT = (N_REQ + N_EXTRA) * MISS_CYC + FLUSH_CYC + 2000;

	logic                  clk;
	logic                  rst_n;
	logic                  req_valid;
	dcache_pkg::core_req_t req;
	logic                  stall;
	logic                  rsp_valid;
	dcache_pkg::word_t     rsp_rdata;
	logic                  wr_start;
	dcache_pkg::mem_req_t  wr_req;
	logic                  wr_done;
	logic                  rd_start;
	logic [31:0]           rd_addr;
	dcache_pkg::line_t     rd_data;
	logic                  rd_valid;
	logic                  flush_start;
	logic                  flush_busy;

	dcache_pkg::word_t     model_mem [WIN_WORDS];
	dcache_pkg::word_t     resp_mem [WIN_WORDS];
	dcache_pkg::core_req_t exp_q [$];
	logic [31:0]           stim_lfsr = SEED;
	logic [31:0]           mem_lfsr = SEED;
	logic                  wb_pending = 1'b0;
	int errors = 0;
	int tests = 0;
	int failed_tests = 0;
	int accepted = 0;
	int responses = 0;
	int rd_count = 0;
	int cycles = 0;

	dcache_top #(.INDEX_W(INDEX_W)) i_dut (
		.clk, .rst_n, .req_valid, .req, .stall, .rsp_valid, .rsp_rdata,
		.wr_start, .wr_req, .wr_done, .rd_start, .rd_addr, .rd_data, .rd_valid,
		.flush_start, .flush_busy
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit taken
	task automatic draw(inout logic [31:0] st, input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			st = lfsr_next(st);
			val = {val[30:0], st[0]};
		end
	endtask

	function automatic dcache_pkg::word_t fill_word(input int widx);
		logic [31:0] a;
		a = widx * 4;
		return (a * 32'h9e3779b1) ^ 32'h5ac30f1e;
	endfunction

	// word 0 of a line sits in the low bits
	function automatic dcache_pkg::line_t line_of(input dcache_pkg::word_t mem [WIN_WORDS],
		input int lidx);
		return {mem[lidx*4+3], mem[lidx*4+2], mem[lidx*4+1], mem[lidx*4]};
	endfunction

	task automatic compare_word(input string name, input dcache_pkg::word_t exp,
		input dcache_pkg::word_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s exp=%h got=%h", name, exp, act);
		end
	endtask

	task automatic compare_line(input string name, input dcache_pkg::line_t exp,
		input dcache_pkg::line_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s exp=%h got=%h", name, exp, act);
		end
	endtask

	task automatic compare_mem_req(input string name, input dcache_pkg::mem_req_t exp,
		input dcache_pkg::mem_req_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s exp=%h got=%h", name, exp, act);
		end
	endtask

	task automatic end_test(input string name, input int base);
		tests++;
		if (errors == base) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", name, errors - base);
		end
	endtask

	// drive at a rising edge, return at the edge that accepts it
	task automatic issue(input logic we, input logic [31:0] addr, input dcache_pkg::word_t wdata);
		dcache_pkg::core_req_t r;
		r.we    = we;
		r.addr  = addr;
		r.wdata = wdata;
		req_valid <= 1'b1;
		req       <= r;
		@(posedge clk);
		while (stall) begin
			@(posedge clk);
		end
		accepted++;
		if (we) begin
			model_mem[addr[11:2]] = wdata;
		end else begin
			r.wdata = model_mem[addr[11:2]];
		end
		exp_q.push_back(r);
	endtask

	task automatic drain();
		req_valid <= 1'b0;
		@(posedge clk);
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d of %0d responses", cycles, responses, accepted);
			$display("=== FAIL ===");
			$finish;
		end
	end

	always @(posedge clk) begin : check_rsp
		dcache_pkg::core_req_t exp;
		if (rst_n && rsp_valid) begin
			responses++;
			if (exp_q.size() == 0) begin
				errors++;
				$display("response arrived with no request outstanding");
			end else begin
				exp = exp_q.pop_front();
				if (!exp.we) begin
					compare_word("rsp_rdata", exp.wdata, rsp_rdata);
				end
			end
		end
	end

	always @(posedge clk) begin : mem_write
		dcache_pkg::mem_req_t wr;
		dcache_pkg::mem_req_t exp;
		logic [31:0] dly;
		int lidx;
		if (rst_n && wr_start) begin
			wr       = wr_req;
			lidx     = wr.addr[11:4];
			exp.addr = {20'h0, wr.addr[11:4], 4'h0};
			exp.data = line_of(model_mem, lidx);
			compare_mem_req("wr_req", exp, wr);
			wb_pending = 1'b1;
			draw(mem_lfsr, 3, dly);
			repeat (dly) @(posedge clk);
			for (int w = 0; w < 4; w++) begin
				resp_mem[lidx*4+w] = wr.data[w*32 +: 32];
			end
			wr_done <= 1'b1;
			@(posedge clk);
			wr_done    <= 1'b0;
			wb_pending = 1'b0;
		end
	end

	always @(posedge clk) begin : mem_read
		logic [31:0] addr;
		logic [31:0] dly;
		if (rst_n && rd_start) begin
			addr = rd_addr;
			rd_count++;
			if (wb_pending || wr_start) begin
				errors++;
				$display("rd_start while a write-back is pending");
			end
			if (addr[31:12] != '0 || addr[3:0] != '0) begin
				errors++;
				$display("rd_addr %h is outside the window or not line aligned", addr);
			end
			draw(mem_lfsr, 3, dly);
			repeat (dly) @(posedge clk);
			rd_data  <= line_of(resp_mem, addr[11:4]);
			rd_valid <= 1'b1;
			@(posedge clk);
			rd_valid <= 1'b0;
		end
	end

	initial begin
		logic [31:0] we;
		logic [31:0] widx;
		logic [31:0] data;
		logic [31:0] gap;
		logic [31:0] addr;
		logic [31:0] cached [8];
		int base;
		int rd_before;
		logic dup;
		rst_n       = 1'b0;
		req_valid   = 1'b0;
		req         = '0;
		wr_done     = 1'b0;
		rd_valid    = 1'b0;
		rd_data     = '0;
		flush_start = 1'b0;
		for (int i = 0; i < WIN_WORDS; i++) begin
			model_mem[i] = fill_word(i);
			resp_mem[i]  = fill_word(i);
		end
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		base = errors;
		if (stall !== 1'b0 || rsp_valid !== 1'b0 || wr_start !== 1'b0 ||
			rd_start !== 1'b0 || flush_busy !== 1'b0) begin
			errors++;
			$display("cache outputs not idle after reset");
		end
		end_test("reset_idle", base);

		base = errors;
		for (int i = 0; i < N_REQ; i++) begin
			draw(stim_lfsr, 1, we);
			draw(stim_lfsr, 10, widx);
			draw(stim_lfsr, 32, data);
			addr = {20'h0, widx[9:0], 2'b00};
			issue(we[0], addr, data);
			cached[i % 8] = addr;
			draw(stim_lfsr, 2, gap);
			if (gap[1:0] == 2'b00) begin
				req_valid <= 1'b0;
				@(posedge clk);
			end
		end
		drain();
		if (responses != accepted) begin
			errors++;
			$display("%0d responses for %0d accepted requests", responses, accepted);
		end
		end_test("random_traffic", base);

		// bit 8 flips the tag but keeps the index, forcing a dirty eviction
		base = errors;
		for (int i = 0; i < 8; i++) begin
			draw(stim_lfsr, 10, widx);
			draw(stim_lfsr, 32, data);
			addr = {20'h0, widx[9:0], 2'b00};
			issue(1'b1, addr, data);
			issue(1'b0, addr, '0);
			issue(1'b1, addr ^ 32'h100, ~data);
			issue(1'b0, addr, '0);
			issue(1'b0, addr ^ 32'h100, '0);
		end
		drain();
		end_test("store_evict", base);

		base = errors;
		flush_start <= 1'b1;
		@(posedge clk);
		flush_start <= 1'b0;
		@(posedge clk);
		while (!flush_busy) begin
			@(posedge clk);
		end
		while (flush_busy) begin
			@(posedge clk);
		end
		for (int l = 0; l < WIN_LINES; l++) begin
			compare_line($sformatf("resp_mem line %0d", l), line_of(model_mem, l),
				line_of(resp_mem, l));
		end
		end_test("flush_writeback", base);

		// a line already refilled in this test would hit, so repeats are skipped
		base = errors;
		for (int k = 0; k < 8; k++) begin
			dup = 1'b0;
			for (int j = 0; j < k; j++) begin
				if (cached[j][11:4] == cached[k][11:4]) begin
					dup = 1'b1;
				end
			end
			if (!dup) begin
				rd_before = rd_count;
				issue(1'b0, cached[k], '0);
				drain();
				if (rd_count == rd_before) begin
					errors++;
					$display("load of %h after flush did not read memory", cached[k]);
				end
			end
		end
		end_test("post_flush_miss", base);

		$display("%0d tests, %0d failed, %0d errors, %0d requests, %0d assertion failures",
			tests, failed_tests, errors, accepted, i_dut.i_ctrl.i_assert.fail_count);
		if (errors == 0 && i_dut.i_ctrl.i_assert.fail_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* rtl/dcache_bus_if.sv */
// data cache output side turning write-back and fill requests into memory strobes
module dcache_bus_if (
	input  logic                 clk,
	input  logic                 rst_n,
	input  dcache_pkg::mem_req_t wb_req,
	input  logic                 wb_go,
	input  logic [31:0]          fill_addr,
	input  logic                 fill_go,
	output logic                 wr_start,
	output dcache_pkg::mem_req_t wr_req,
	input  logic                 wr_done,
	output logic                 rd_start,
	output logic [31:0]          rd_addr,
	input  logic                 rd_valid,
	input  dcache_pkg::line_t    rd_data,
	output logic                 wb_done,
	output logic                 fill_done,
	output dcache_pkg::line_t    fill_data
);

	// start strobes trail the controller go pulses by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_start <= 1'b0;
			rd_start <= 1'b0;
		end else begin
			wr_start <= wb_go;
			rd_start <= fill_go;
		end
	end

	// address and line stay put until the next go,
	// which cannot come before the finish pulse
	always_ff @(posedge clk) begin
		if (wb_go) begin
			wr_req <= wb_req;
		end
		if (fill_go) begin
			rd_addr <= fill_addr;
		end
	end

	// finish pulses and fill data pass straight back
	assign wb_done   = wr_done;
	assign fill_done = rd_valid;
	assign fill_data = rd_data;

endmodule

/* rtl/dcache_ctrl.sv */
// data cache controller with tag compare, miss sequencer, store merge and flush walker
module dcache_ctrl #(
	parameter int  INDEX_W = 9,
	localparam int TAG_W   = 28 - INDEX_W
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  dcache_pkg::core_req_t ma_req,
	input  logic                  ma_valid,
	input  logic [INDEX_W-1:0]    lookup_index,
	input  logic [TAG_W-1:0]      tag_rdata,
	input  dcache_pkg::line_t     line_rdata,
	output logic                  tag_wen,
	output logic [TAG_W-1:0]      tag_wdata,
	output logic                  line_wen,
	output dcache_pkg::line_t     line_wdata,
	output logic [INDEX_W-1:0]    ram_waddr,
	output logic [INDEX_W-1:0]    ram_raddr,
	output logic                  stall,
	output logic                  rsp_valid,
	output dcache_pkg::word_t     rsp_rdata,
	output dcache_pkg::mem_req_t  wb_req,
	output logic                  wb_go,
	input  logic                  wb_done,
	output logic [31:0]           fill_addr,
	output logic                  fill_go,
	input  logic                  fill_done,
	input  dcache_pkg::line_t     fill_data,
	input  logic                  flush_start,
	output logic                  flush_busy
);

	localparam int NSETS  = 2 ** INDEX_W;
	localparam int WSEL_W = dcache_pkg::OFFSET_W - 2;

	dcache_pkg::miss_state_e state;
	dcache_pkg::miss_state_e state_nxt;

	logic [NSETS-1:0]   valid_q;
	logic [NSETS-1:0]   dirty_q;
	logic [INDEX_W-1:0] ma_index;
	logic [TAG_W-1:0]   ma_tag;
	logic [WSEL_W-1:0]  ma_word;
	logic               in_idle;
	logic               hit;
	logic               req_hit;
	logic               req_miss;
	logic               victim_dirty;
	logic               store_hit;

	logic [INDEX_W-1:0] flush_index;
	logic               flush_active;
	logic               flush_pend;
	logic               flush_go;
	logic               flush_dirty;
	logic               flush_last;
	logic               flush_step;
	logic               fl_wait;

	dcache_pkg::line_t  refill_line;
	dcache_pkg::line_t  fwd_line;
	logic               fwd_valid;
	logic [INDEX_W-1:0] fwd_index;
	dcache_pkg::line_t  line_cur;
	dcache_pkg::line_t  store_line;
	logic [INDEX_W-1:0] wb_index;

	assign ma_index = ma_req.addr[INDEX_W+dcache_pkg::OFFSET_W-1:dcache_pkg::OFFSET_W];
	assign ma_tag   = ma_req.addr[31:INDEX_W+dcache_pkg::OFFSET_W];
	assign ma_word  = ma_req.addr[dcache_pkg::OFFSET_W-1:2];

	// a line written on the previous edge is not yet visible on the RAM output
	assign line_cur = (fwd_valid && fwd_index == ma_index) ? fwd_line : line_rdata;

	// lookup is valid only while idle since RAM data then matches the MA index
	assign in_idle      = (state == dcache_pkg::IDLE);
	assign hit          = valid_q[ma_index] && (tag_rdata == ma_tag);
	assign req_hit      = in_idle && ma_valid && hit;
	assign req_miss     = in_idle && ma_valid && !hit;
	assign victim_dirty = valid_q[ma_index] && dirty_q[ma_index];
	assign store_hit    = req_hit && ma_req.we;

	// flush waits behind a miss but may start in the cycle of a hit
	assign flush_go     = in_idle && !req_miss && (flush_start || flush_pend);
	assign flush_active = (state == dcache_pkg::FLUSH_RD) || (state == dcache_pkg::FLUSH_WB);
	assign flush_dirty  = valid_q[flush_index] && dirty_q[flush_index];
	assign flush_last   = (flush_index == '0);
	assign flush_step   = (state == dcache_pkg::FLUSH_WB) &&
		((!fl_wait && !flush_dirty) || (fl_wait && wb_done));

	always_comb begin
		state_nxt = state;
		case (state)
			dcache_pkg::IDLE: begin
				if (req_miss) begin
					state_nxt = victim_dirty ? dcache_pkg::WBACK : dcache_pkg::FILL;
				end else if (flush_go) begin
					state_nxt = dcache_pkg::FLUSH_RD;
				end
			end
			dcache_pkg::WBACK: begin
				if (wb_done) begin
					state_nxt = dcache_pkg::FILL;
				end
			end
			dcache_pkg::FILL: begin
				if (fill_done) begin
					state_nxt = dcache_pkg::REFILL_WR;
				end
			end
			dcache_pkg::REFILL_WR: state_nxt = dcache_pkg::REREAD;
			dcache_pkg::REREAD:    state_nxt = dcache_pkg::IDLE;
			dcache_pkg::FLUSH_RD:  state_nxt = dcache_pkg::FLUSH_WB;
			dcache_pkg::FLUSH_WB: begin
				if (flush_step) begin
					state_nxt = flush_last ? dcache_pkg::IDLE : dcache_pkg::FLUSH_RD;
				end
			end
			default: state_nxt = dcache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= dcache_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// store data goes into its word slot of the current line
	always_comb begin
		store_line = line_cur;
		store_line[ma_word*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] = ma_req.wdata;
	end

	assign rsp_rdata = line_cur[ma_word*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
	assign rsp_valid = req_hit;
	assign stall     = !in_idle || req_miss;
	assign flush_busy = flush_active || (flush_pend && !in_idle);

	// RAM ports
	assign ram_raddr  = flush_active ? flush_index : lookup_index;
	assign ram_waddr  = ma_index;
	assign tag_wen    = (state == dcache_pkg::REFILL_WR);
	assign tag_wdata  = ma_tag;
	assign line_wen   = store_hit || (state == dcache_pkg::REFILL_WR);
	assign line_wdata = (state == dcache_pkg::REFILL_WR) ? refill_line : store_line;

	// victim write-back for a miss or for the flush walker
	assign wb_index    = flush_active ? flush_index : ma_index;
	assign wb_req.addr = {tag_rdata, wb_index, {dcache_pkg::OFFSET_W{1'b0}}};
	assign wb_req.data = flush_active ? line_rdata : line_cur;
	assign wb_go       = (req_miss && victim_dirty) ||
		((state == dcache_pkg::FLUSH_WB) && !fl_wait && flush_dirty);

	assign fill_addr = {ma_req.addr[31:dcache_pkg::OFFSET_W], {dcache_pkg::OFFSET_W{1'b0}}};
	assign fill_go   = (req_miss && !victim_dirty) || ((state == dcache_pkg::WBACK) && wb_done);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (flush_step && flush_last) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			// refilled line starts clean
			if (tag_wen) begin
				valid_q[ma_index] <= 1'b1;
				dirty_q[ma_index] <= 1'b0;
			end
			if (store_hit) begin
				dirty_q[ma_index] <= 1'b1;
			end
			if (flush_step && fl_wait) begin
				dirty_q[flush_index] <= 1'b0;
			end
		end
	end

	// flush walks down from the top index
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flush_index <= '0;
			flush_pend  <= 1'b0;
			fl_wait     <= 1'b0;
		end else begin
			if (flush_go) begin
				flush_index <= '1;
			end else if (flush_step && !flush_last) begin
				flush_index <= flush_index - 1'b1;
			end
			if (flush_go) begin
				flush_pend <= 1'b0;
			end else if (flush_start && !flush_active) begin
				flush_pend <= 1'b1;
			end
			if (flush_step) begin
				fl_wait <= 1'b0;
			end else if ((state == dcache_pkg::FLUSH_WB) && flush_dirty) begin
				fl_wait <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fwd_valid <= 1'b0;
		end else begin
			fwd_valid <= line_wen;
		end
	end

	always_ff @(posedge clk) begin
		if (line_wen) begin
			fwd_index <= ram_waddr;
			fwd_line  <= line_wdata;
		end
		if ((state == dcache_pkg::FILL) && fill_done) begin
			refill_line <= fill_data;
		end
	end

endmodule

/* rtl/dcache_line_ram.sv */
// one-read one-write synchronous RAM used for cache tags and data lines
module dcache_line_ram #(
	parameter type payload_t = logic [127:0],
	parameter int  INDEX_W   = 9
) (
	input  logic               clk,
	input  logic [INDEX_W-1:0] raddr,
	output payload_t           rdata,
	input  logic [INDEX_W-1:0] waddr,
	input  payload_t           wdata,
	input  logic               wen
);

	localparam int DEPTH = 2 ** INDEX_W;

	payload_t mem [DEPTH];

	// read returns the old contents when both ports hit the same entry
	always_ff @(posedge clk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr];
	end

endmodule

/* rtl/dcache_pkg.sv */
// data cache shared widths, core and memory request types, controller states
package dcache_pkg;

	// core word and cache line geometry
	localparam int WORD_W   = 32;
	localparam int LINE_W   = 128;
	localparam int OFFSET_W = 4;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [LINE_W-1:0] line_t;

	// one word access from the memory-access stage
	typedef struct packed {
		logic        we;
		logic [31:0] addr;
		word_t       wdata;
	} core_req_t;

	// one line transfer to or from memory
	// data only matters on the write channel
	typedef struct packed {
		logic [31:0] addr;
		line_t       data;
	} mem_req_t;

	// miss and flush sequencer
	typedef enum logic [2:0] {
		IDLE,
		WBACK,
		FILL,
		REFILL_WR,
		REREAD,
		FLUSH_RD,
		FLUSH_WB
	} miss_state_e;

endpackage

/* rtl/dcache_req_stage.sv */
// data cache input side holding the core request in the MA register
module dcache_req_stage #(
	parameter int INDEX_W = 9
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req_valid,
	input  dcache_pkg::core_req_t req,
	input  logic                  stall,
	output dcache_pkg::core_req_t ma_req,
	output logic                  ma_valid,
	output logic [INDEX_W-1:0]    lookup_index
);

	logic [INDEX_W-1:0] req_index;
	logic [INDEX_W-1:0] ma_index;

	assign req_index = req.addr[INDEX_W+dcache_pkg::OFFSET_W-1:dcache_pkg::OFFSET_W];
	assign ma_index  = ma_req.addr[INDEX_W+dcache_pkg::OFFSET_W-1:dcache_pkg::OFFSET_W];

	// request is taken on any edge where the cache does not stall
	// an empty slot follows a completed request with nothing behind it
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ma_valid <= 1'b0;
		end else if (!stall) begin
			ma_valid <= req_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && req_valid) begin
			ma_req <= req;
		end
	end

	// RAMs read the incoming index while advancing
	// a stalled request keeps its own index so it can be re-read after a refill
	always_comb begin
		if (stall) begin
			lookup_index = ma_index;
		end else begin
			lookup_index = req_index;
		end
	end

endmodule

/* rtl/dcache_top.sv */
// write-back direct-mapped data cache for the memory-access stage
module dcache_top #(
	parameter int INDEX_W = 9
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req_valid,
	input  dcache_pkg::core_req_t req,
	output logic                  stall,
	output logic                  rsp_valid,
	output dcache_pkg::word_t     rsp_rdata,
	output logic                  wr_start,
	output dcache_pkg::mem_req_t  wr_req,
	input  logic                  wr_done,
	output logic                  rd_start,
	output logic [31:0]           rd_addr,
	input  dcache_pkg::line_t     rd_data,
	input  logic                  rd_valid,
	input  logic                  flush_start,
	output logic                  flush_busy
);

	localparam int TAG_W = 28 - INDEX_W;

	typedef logic [TAG_W-1:0] tag_t;

	dcache_pkg::core_req_t ma_req;
	logic                  ma_valid;
	logic [INDEX_W-1:0]    lookup_index;
	logic [INDEX_W-1:0]    ram_raddr;
	logic [INDEX_W-1:0]    ram_waddr;
	tag_t                  tag_rdata;
	tag_t                  tag_wdata;
	logic                  tag_wen;
	dcache_pkg::line_t     line_rdata;
	dcache_pkg::line_t     line_wdata;
	logic                  line_wen;
	dcache_pkg::mem_req_t  wb_req;
	logic                  wb_go;
	logic                  wb_done;
	logic [31:0]           fill_addr;
	logic                  fill_go;
	logic                  fill_done;
	dcache_pkg::line_t     fill_data;

	dcache_req_stage #(.INDEX_W(INDEX_W)) i_req_stage (
		.clk, .rst_n, .req_valid, .req, .stall, .ma_req, .ma_valid, .lookup_index
	);

	// tag and data arrays share read and write indices
	dcache_line_ram #(.payload_t(tag_t), .INDEX_W(INDEX_W)) i_tag_ram (
		.clk, .raddr(ram_raddr), .rdata(tag_rdata),
		.waddr(ram_waddr), .wdata(tag_wdata), .wen(tag_wen)
	);

	dcache_line_ram #(.payload_t(dcache_pkg::line_t), .INDEX_W(INDEX_W)) i_data_ram (
		.clk, .raddr(ram_raddr), .rdata(line_rdata),
		.waddr(ram_waddr), .wdata(line_wdata), .wen(line_wen)
	);

	dcache_ctrl #(.INDEX_W(INDEX_W)) i_ctrl (
		.clk, .rst_n, .ma_req, .ma_valid, .lookup_index,
		.tag_rdata, .line_rdata, .tag_wen, .tag_wdata, .line_wen, .line_wdata,
		.ram_waddr, .ram_raddr, .stall, .rsp_valid, .rsp_rdata,
		.wb_req, .wb_go, .wb_done, .fill_addr, .fill_go, .fill_done, .fill_data,
		.flush_start, .flush_busy
	);

	dcache_bus_if i_bus_if (
		.clk, .rst_n, .wb_req, .wb_go, .fill_addr, .fill_go,
		.wr_start, .wr_req, .wr_done, .rd_start, .rd_addr, .rd_valid, .rd_data,
		.wb_done, .fill_done, .fill_data
	);

endmodule
